//--- verilog.f
hdl/fifo_pkg.sv
hdl/fifo_memory_dp.sv
hdl/fifo_sync.sv
hdl/fifo_mem_bist.sv
hdl/fifo_top.sv
sim/fifo_checker.sv
sim/tb_fifo.sv

//--- Makefile
# Verilator build and run of the FIFO testbench
VERILATOR ?= verilator
TOP       ?= tb_fifo
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_fifo.sv
// directed testbench for fifo_top; queue model predicts data and flags, run as the sim top
module tb_fifo;
   timeunit 1ns;
   timeprecision 100ps;
   import fifo_pkg::*;

   localparam int SEED    = 65815;
   localparam int ACK_MAX = 8 * DEPTH + 40;   // cycles allowed per handshake edge

   logic clk = 1'b0;
   logic nreset, clear, wr_en, rd_en, bist_req;
   logic [DATA_W-1:0] wr_din;
   logic wr_full, wr_almost_full, wr_prog_full, rd_empty, bist_ack, bist_fail;
   logic [CNT_W-1:0]  wr_count;
   logic [DATA_W-1:0] rd_dout;

   logic [DATA_W-1:0] model_q [$];   // expected contents, oldest first
   logic [DATA_W-1:0] exp_dout;      // word rd_dout should hold
   logic              dout_known;    // cleared after BIST overwrites the read register
   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;

   always #2 clk = ~clk;   // 4 ns period

   fifo_top dut_i (.*);

   //############################################################
   // check helpers
   //############################################################
   task automatic check(input logic ok, input string msg);
      assert (ok)
      else
      begin
         $display("FAIL %0t: %s", $time, msg);
         errors++;
      end
   endtask

   // compare every output with the model, called mid-cycle
   task automatic check_state();
      int n;
      n = model_q.size();
      check(int'(wr_count) == n, $sformatf("wr_count %0d, expected %0d", wr_count, n));
      check(rd_empty == (n == 0), $sformatf("rd_empty %0b with %0d entries", rd_empty, n));
      check(wr_full == (n == DEPTH), $sformatf("wr_full %0b with %0d entries", wr_full, n));
      check(wr_almost_full == (n == DEPTH - 1),
            $sformatf("wr_almost_full %0b with %0d entries", wr_almost_full, n));
      check(wr_prog_full == (n >= PROG_FULL),
            $sformatf("wr_prog_full %0b with %0d entries", wr_prog_full, n));
      if (dout_known)
         check(rd_dout == exp_dout, $sformatf("rd_dout %h, expected %h", rd_dout, exp_dout));
   endtask

   // one clock of traffic; model follows the accept rules
   task automatic drive_cycle(input logic we, input logic re, input logic [DATA_W-1:0] din);
      logic acc_w;
      logic acc_r;
      @(posedge clk);
      wr_en  <= we;
      rd_en  <= re;
      wr_din <= din;
      @(negedge clk);
      check_state();                                // results of all earlier edges
      acc_w = we && (model_q.size() < DEPTH);       // full blocks the write
      acc_r = re && (model_q.size() > 0);           // empty blocks the read
      if (acc_r)
      begin
         exp_dout   = model_q.pop_front();
         dout_known = 1'b1;
      end
      if (acc_w)
         model_q.push_back(din);
   endtask

   task automatic wait_ack(input logic level);
      int n;
      for (n = 0; n < ACK_MAX; n++)
      begin
         @(negedge clk);
         if (bist_ack == level)
            break;
      end
      if (n == ACK_MAX)
      begin
         $display("timeout: bist_ack never went to %0b within %0d cycles", level, ACK_MAX);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors == err_before)
         $display("test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %s: FAILED, %0d errors", name, errors - err_before);
      end
   endtask

   //############################################################
   // tests
   //############################################################
   task automatic test_fill_drain();
      int e0;
      e0 = errors;
      repeat (DEPTH) drive_cycle(1'b1, 1'b0, $urandom);
      drive_cycle(1'b1, 1'b0, $urandom);           // full, must be dropped
      repeat (DEPTH) drive_cycle(1'b0, 1'b1, '0);
      drive_cycle(1'b0, 1'b0, '0);                 // last word and empty flag
      report_test("fill_drain", e0);
   endtask

   task automatic test_mixed();
      int e0;
      e0 = errors;
      repeat (DEPTH / 2) drive_cycle(1'b1, 1'b0, $urandom);
      repeat (48) drive_cycle(1'($urandom), 1'($urandom), $urandom);
      while (model_q.size() > 0)
         drive_cycle(1'b0, 1'b1, '0);
      drive_cycle(1'b0, 1'b0, '0);
      report_test("mixed_rd_wr", e0);
   endtask

   task automatic test_read_empty();
      int e0;
      e0 = errors;
      repeat (3) drive_cycle(1'b0, 1'b1, '0);      // rd_dout must hold
      drive_cycle(1'b0, 1'b0, '0);
      report_test("read_empty", e0);
   endtask

   task automatic test_clear();
      int e0;
      e0 = errors;
      repeat (5) drive_cycle(1'b1, 1'b0, $urandom);
      @(posedge clk);
      wr_en <= 1'b0;
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      model_q.delete();
      drive_cycle(1'b1, 1'b0, $urandom);           // fresh word after flush
      drive_cycle(1'b0, 1'b1, '0);
      drive_cycle(1'b0, 1'b0, '0);
      report_test("clear", e0);
   endtask

   task automatic test_bist();
      int e0;
      e0 = errors;
      repeat (6) drive_cycle(1'b1, 1'b0, $urandom);
      @(posedge clk);
      wr_en    <= 1'b0;
      bist_req <= 1'b1;
      wait_ack(1'b1);
      check(bist_fail == 1'b0, "bist_fail set on a good memory");
      model_q.delete();                            // test leaves the FIFO empty
      dout_known = 1'b0;
      check_state();
      @(posedge clk);
      bist_req <= 1'b0;
      wait_ack(1'b0);
      repeat (3) drive_cycle(1'b1, 1'b0, $urandom);
      repeat (3) drive_cycle(1'b0, 1'b1, '0);
      drive_cycle(1'b0, 1'b0, '0);
      report_test("bist", e0);
   endtask

   initial
   begin
      nreset = 1'b0;
      clear = 1'b0;
      wr_en = 1'b0;
      rd_en = 1'b0;
      bist_req = 1'b0;
      wr_din = '0;
      exp_dout = '0;                               // read register resets to zero
      dout_known = 1'b1;
      void'($urandom(SEED));
      repeat (16) @(posedge clk);
      nreset <= 1'b1;
      @(negedge clk);
      check_state();
      check(!bist_ack && !bist_fail, "bist_ack or bist_fail high after reset");
      test_fill_drain();
      test_mixed();
      test_read_empty();
      test_clear();
      test_bist();
      errors += dut_i.checker_i.fail_count;        // bound protocol assertions
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- sim/fifo_checker.sv
// concurrent protocol assertions on fifo_top, attached to every fifo_top instance by bind
module fifo_checker
(
   input logic                       clk,
   input logic                       nreset,
   input logic                       wr_full,
   input logic                       rd_empty,
   input logic [fifo_pkg::CNT_W-1:0] wr_count,
   input logic                       bist_req,
   input logic                       bist_ack
);
   timeunit 1ns;
   timeprecision 100ps;
   import fifo_pkg::*;

   int fail_count = 0;   // assertion failures so far

   //############################################################
   // fifo flags
   //############################################################
   // full only at DEPTH, empty only at zero, hence never both
   full_not_empty: assert property (@(posedge clk) disable iff (!nreset)
      (!wr_full || (wr_count == CNT_W'(DEPTH))) && (!rd_empty || (wr_count == '0)))
      else
      begin
         fail_count++;
         $error("wr_full or rd_empty disagrees with wr_count");
      end

   count_in_range: assert property (@(posedge clk) disable iff (!nreset)
      wr_count <= CNT_W'(DEPTH))  // never past DEPTH
      else
      begin
         fail_count++;
         $error("wr_count above DEPTH");
      end

   //############################################################
   // four-phase bist handshake
   //############################################################
   ack_needs_req: assert property (@(posedge clk) disable iff (!nreset)
      $rose(bist_ack) |-> bist_req)
      else
      begin
         fail_count++;
         $error("bist_ack rose without bist_req");
      end

   ack_after_req_low: assert property (@(posedge clk) disable iff (!nreset)
      $fell(bist_ack) |-> !$past(bist_req))  // req dropped first
      else
      begin
         fail_count++;
         $error("bist_ack fell while bist_req was still high");
      end

endmodule

bind fifo_top fifo_checker checker_i
(
   .clk      (clk),
   .nreset   (nreset),
   .wr_full  (wr_full),
   .rd_empty (rd_empty),
   .wr_count (wr_count),
   .bist_req (bist_req),
   .bist_ack (bist_ack)
);

//--- hdl/fifo_top.sv
// top level: synchronous FIFO with its memory self-test engine routed through the FIFO
module fifo_top
(
   input  logic                        clk,
   input  logic                        nreset,
   input  logic                        clear,
   // write port
   input  logic                        wr_en,
   input  logic [fifo_pkg::DATA_W-1:0] wr_din,
   output logic                        wr_full,
   output logic                        wr_almost_full,
   output logic                        wr_prog_full,
   output logic [fifo_pkg::CNT_W-1:0]  wr_count,
   // read port
   input  logic                        rd_en,
   output logic [fifo_pkg::DATA_W-1:0] rd_dout,
   output logic                        rd_empty,
   // self-test control
   input  logic                        bist_req,
   output logic                        bist_ack,
   output logic                        bist_fail
);
   import fifo_pkg::*;

   logic              bist_en;     // engine owns the array
   logic              bist_we;
   logic [ADDR_W-1:0] bist_addr;
   logic [DATA_W-1:0] bist_din;

   fifo_sync fifo_i
   (
      .clk            (clk),
      .nreset         (nreset),
      .clear          (clear),
      .wr_en          (wr_en),
      .wr_din         (wr_din),
      .wr_full        (wr_full),
      .wr_almost_full (wr_almost_full),
      .wr_prog_full   (wr_prog_full),
      .wr_count       (wr_count),
      .rd_en          (rd_en),
      .rd_dout        (rd_dout),
      .rd_empty       (rd_empty),
      .bist_en        (bist_en),
      .bist_we        (bist_we),
      .bist_addr      (bist_addr),
      .bist_din       (bist_din)
   );

   fifo_mem_bist bist_i
   (
      .clk       (clk),
      .nreset    (nreset),
      .bist_req  (bist_req),
      .bist_ack  (bist_ack),
      .bist_fail (bist_fail),
      .bist_en   (bist_en),
      .bist_we   (bist_we),
      .bist_addr (bist_addr),
      .bist_din  (bist_din),
      .bist_dout (rd_dout)      // read-back shares the FIFO output register
   );

endmodule

//--- hdl/fifo_mem_bist.sv
// two-pass write/read-compare memory test, started by a four-phase req/ack handshake
module fifo_mem_bist
(
   input  logic                        clk,
   input  logic                        nreset,
   // start handshake
   input  logic                        bist_req,
   output logic                        bist_ack,
   output logic                        bist_fail,   // valid with ack, sticky to next start
   // memory access
   output logic                        bist_en,
   output logic                        bist_we,
   output logic [fifo_pkg::ADDR_W-1:0] bist_addr,
   output logic [fifo_pkg::DATA_W-1:0] bist_din,
   input  logic [fifo_pkg::DATA_W-1:0] bist_dout    // registered read data
);
   import fifo_pkg::*;

   bist_state_t       state;
   logic [ADDR_W-1:0] addr;       // walks every entry
   logic              pass;       // 0 = pattern, 1 = inverse
   logic              cmp_valid;  // read data due this cycle
   logic [DATA_W-1:0] exp_word;   // expected data for that read
   logic [DATA_W-1:0] pat_word;   // pattern for current addr and pass

   // pattern xor address replicated over the word
   assign pat_word = (pass ? ~BIST_PAT : BIST_PAT) ^ {(DATA_W / ADDR_W){addr}};

   assign bist_en   = (state == BIST_WRITE) || (state == BIST_READ) ||
                      (state == BIST_CHECK_LAST);
   assign bist_we   = (state == BIST_WRITE);
   assign bist_addr = addr;
   assign bist_din  = pat_word;

   //############################################################
   // sequencer
   //############################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state     <= BIST_IDLE;
         addr      <= '0;
         pass      <= 1'b0;
         bist_ack  <= 1'b0;
         bist_fail <= 1'b0;
         cmp_valid <= 1'b0;
      end
      else
      begin
         cmp_valid <= (state == BIST_READ);   // data lands one edge after the read
         // compare slot for the previous read
         if (cmp_valid && (bist_dout != exp_word))
            bist_fail <= 1'b1;
         case (state)
            BIST_IDLE:
            begin
               if (bist_req)
               begin
                  state     <= BIST_WRITE;
                  addr      <= '0;
                  pass      <= 1'b0;
                  bist_fail <= 1'b0;   // new run, fresh result
               end
            end
            BIST_WRITE:
            begin
               addr <= addr + 1'b1;
               if (addr == ADDR_W'(DEPTH - 1))
                  state <= BIST_READ;   // addr wraps to zero
            end
            BIST_READ:
            begin
               addr <= addr + 1'b1;
               if (addr == ADDR_W'(DEPTH - 1))
                  state <= BIST_CHECK_LAST;
            end
            BIST_CHECK_LAST:
            begin
               // last word of the pass compared here
               if (!pass)
               begin
                  pass  <= 1'b1;
                  state <= BIST_WRITE;
               end
               else
                  state <= BIST_DONE;
            end
            BIST_DONE:
            begin
               if (!bist_ack)
                  bist_ack <= 1'b1;    // result is settled
               else if (!bist_req)
               begin
                  bist_ack <= 1'b0;    // handshake closes
                  state    <= BIST_IDLE;
               end
            end
            default:
               state <= BIST_IDLE;
         endcase
      end
   end

   // expected word, lines up with the read data one edge later
   always_ff @(posedge clk)
   begin
      if (state == BIST_READ)
         exp_word <= pat_word;
   end

endmodule

//--- hdl/fifo_sync.sv
// synchronous FIFO control: pointers, count and flags around the dual-port array
module fifo_sync
(
   input  logic                        clk,
   input  logic                        nreset,
   input  logic                        clear,           // sync flush
   // write side
   input  logic                        wr_en,
   input  logic [fifo_pkg::DATA_W-1:0] wr_din,
   output logic                        wr_full,
   output logic                        wr_almost_full,  // one entry left
   output logic                        wr_prog_full,    // at or above PROG_FULL
   output logic [fifo_pkg::CNT_W-1:0]  wr_count,        // exact entry count
   // read side
   input  logic                        rd_en,
   output logic [fifo_pkg::DATA_W-1:0] rd_dout,         // next cycle data
   output logic                        rd_empty,
   // self-test access, passed to the array
   input  logic                        bist_en,
   input  logic                        bist_we,
   input  logic [fifo_pkg::ADDR_W-1:0] bist_addr,
   input  logic [fifo_pkg::DATA_W-1:0] bist_din
);
   import fifo_pkg::*;

   logic [ADDR_W:0] wr_ptr;      // msb is the wrap bit
   logic [ADDR_W:0] rd_ptr;
   logic            ptr_match;   // low bits equal
   logic            fifo_write;  // accepted write
   logic            fifo_read;   // accepted read

   //############################################################
   // flags
   //############################################################
   assign ptr_match = (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
   assign wr_full   = ptr_match & (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);  // lapped once
   assign rd_empty  = ptr_match & (wr_ptr[ADDR_W] == rd_ptr[ADDR_W]);

   assign wr_almost_full = (wr_count == CNT_W'(DEPTH - 1));
   assign wr_prog_full   = (wr_count >= CNT_W'(PROG_FULL));

   // BIST owns the array, so FIFO traffic is blocked
   assign fifo_write = wr_en & ~wr_full & ~bist_en;
   assign fifo_read  = rd_en & ~rd_empty & ~bist_en;

   //############################################################
   // pointers and count
   //############################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         wr_count <= '0;
      end
      else if (clear || bist_en)   // flush, also held empty during self-test
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         wr_count <= '0;
      end
      else
      begin
         if (fifo_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (fifo_read)
            rd_ptr <= rd_ptr + 1'b1;
         // both at once leaves count alone
         if (fifo_write && !fifo_read)
            wr_count <= wr_count + 1'b1;
         else if (fifo_read && !fifo_write)
            wr_count <= wr_count - 1'b1;
      end
   end

   //############################################################
   // storage
   //############################################################
   fifo_memory_dp mem_i
   (
      .clk       (clk),
      .nreset    (nreset),
      .wr_en     (fifo_write),                // only accepted ops reach the array
      .wr_addr   (wr_ptr[ADDR_W-1:0]),
      .wr_din    (wr_din),
      .rd_en     (fifo_read),
      .rd_addr   (rd_ptr[ADDR_W-1:0]),
      .rd_dout   (rd_dout),
      .bist_en   (bist_en),
      .bist_we   (bist_we),
      .bist_addr (bist_addr),
      .bist_din  (bist_din)
   );

endmodule

//--- hdl/fifo_memory_dp.sv
// dual-port register array with registered read data; BIST port overrides both FIFO ports
module fifo_memory_dp
(
   input  logic                        clk,
   input  logic                        nreset,     // async, clears read register
   // write port
   input  logic                        wr_en,
   input  logic [fifo_pkg::ADDR_W-1:0] wr_addr,
   input  logic [fifo_pkg::DATA_W-1:0] wr_din,
   // read port
   input  logic                        rd_en,
   input  logic [fifo_pkg::ADDR_W-1:0] rd_addr,
   output logic [fifo_pkg::DATA_W-1:0] rd_dout,    // valid the edge after rd_en
   // self-test port
   input  logic                        bist_en,
   input  logic                        bist_we,
   input  logic [fifo_pkg::ADDR_W-1:0] bist_addr,
   input  logic [fifo_pkg::DATA_W-1:0] bist_din
);
   import fifo_pkg::*;

   logic [DATA_W-1:0] mem [DEPTH];   // storage, no reset

   logic              mem_we;        // muxed write strobe
   logic [ADDR_W-1:0] mem_waddr;
   logic [DATA_W-1:0] mem_wdata;
   logic              mem_re;        // muxed read strobe
   logic [ADDR_W-1:0] mem_raddr;

   //############################################################
   // port select, BIST wins when enabled
   //############################################################
   assign mem_we    = bist_en ? bist_we : wr_en;
   assign mem_waddr = bist_en ? bist_addr : wr_addr;
   assign mem_wdata = bist_en ? bist_din : wr_din;
   assign mem_re    = bist_en ? ~bist_we : rd_en;   // BIST reads when not writing
   assign mem_raddr = bist_en ? bist_addr : rd_addr;

   // write side
   always_ff @(posedge clk)
   begin
      if (mem_we)
         mem[mem_waddr] <= mem_wdata;
   end

   // registered read, holds between reads
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rd_dout <= '0;
      else if (mem_re)
         rd_dout <= mem[mem_raddr];
   end

endmodule

//--- hdl/fifo_pkg.sv
// shared sizes, BIST state encoding and test pattern; imported by every FIFO and BIST file
package fifo_pkg;

   //############################################################
   // fifo geometry
   //############################################################
   localparam int DATA_W    = 32;             // word width
   localparam int DEPTH     = 16;             // entries
   localparam int ADDR_W    = $clog2(DEPTH);  // 4 for 16 entries
   localparam int CNT_W     = ADDR_W + 1;     // count reaches DEPTH itself
   localparam int PROG_FULL = 12;             // programmable full level

   //############################################################
   // memory self-test
   //############################################################

   // first pass pattern, second pass uses the inverse
   // each word is also xored with its address repeated across the word
   localparam logic [DATA_W-1:0] BIST_PAT = 32'hA5C3_5A3C;

   // engine states
   typedef enum logic [2:0]
   {
      BIST_IDLE,        // waiting for bist_req
      BIST_WRITE,       // writing pattern to every address
      BIST_READ,        // reading every address back
      BIST_CHECK_LAST,  // compare slot for the final read of a pass
      BIST_DONE         // ack raised, waiting for req to drop
   } bist_state_t;

endpackage
